// ==== src/eye_tracker_pkg.sv ====
`default_nettype none

package eye_tracker_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    typedef logic [7:0]  pixel_t;
    typedef logic [9:0]  coord_t;
    typedef logic [19:0] count_t;
    typedef logic [27:0] sum_t;
    typedef logic [7:0]  frame_id_t;
    typedef logic [7:0]  byte_t;

    // Result buffer, also the initial credit count
    localparam int RESULT_DEPTH = 4;
    localparam int RESULT_PTR_W = $clog2(RESULT_DEPTH);
    localparam int RESULT_CNT_W = $clog2(RESULT_DEPTH + 1);

    // One quotient bit per step
    localparam int STEP_W = $clog2($bits(sum_t));

    // ------------------------------
    // UART framing
    // ------------------------------
    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int PACKET_BYTES = 9;
    localparam int BYTE_IDX_W   = $clog2(PACKET_BYTES);
    localparam int BIT_IDX_W    = $clog2($bits(byte_t));

    localparam byte_t SYNC_BYTE = 8'hA5;

    // State machines
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_X,
        DIV_Y,
        DIV_SEND
    } div_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

// ==== src/camera_input.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_input import eye_tracker_pkg::*; (
    input  wire         cclk,
    input  wire         rst,
    input  wire         fval,
    input  wire         lval,
    input  wire         dval,
    input  wire pixel_t data,
    output logic        pixel_valid,
    output pixel_t      pixel,
    output coord_t      x,
    output coord_t      y,
    output logic        frame_end,
    output frame_id_t   frame_id
);

    logic   fval_q;
    logic   lval_q;
    logic   frame_start;
    logic   line_end;
    logic   pix_in;
    coord_t x_cnt;
    coord_t y_cnt;
    coord_t x_cur;
    coord_t y_cur;

    assign frame_start = fval & ~fval_q;
    assign line_end    = lval_q & ~lval;
    assign pix_in      = fval & lval & dval;

    // First pixel may arrive together with the fval edge
    assign x_cur = frame_start ? '0 : x_cnt;
    assign y_cur = frame_start ? '0 : y_cnt;

    always_ff @(posedge cclk) begin
        if (rst) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            pixel_valid <= 1'b0;
            frame_end   <= 1'b0;
            x_cnt       <= '0;
            y_cnt       <= '0;
            frame_id    <= '1;
        end else begin
            fval_q      <= fval;
            lval_q      <= lval;
            pixel_valid <= pix_in;
            frame_end   <= fval_q & ~fval;
            if (frame_start) begin
                frame_id <= frame_id + 1'b1;
            end
            if (line_end && !frame_start) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cur + coord_t'(pix_in);
                y_cnt <= y_cur;
            end
        end
    end

    always_ff @(posedge cclk) begin
        pixel <= data;
        x     <= x_cur;
        y     <= y_cur;
    end

endmodule

`default_nettype wire

// ==== src/centroid_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module centroid_accum import eye_tracker_pkg::*; (
    input  wire            cclk,
    input  wire            rst,
    input  wire            pixel_valid,
    input  wire pixel_t    pixel,
    input  wire coord_t    x,
    input  wire coord_t    y,
    input  wire            frame_end,
    input  wire frame_id_t frame_id,
    input  wire pixel_t    threshold,
    output logic           sum_valid,
    output count_t         sum_s,
    output sum_t           sum_x,
    output sum_t           sum_y,
    output frame_id_t      sum_id
);

    count_t acc_s;
    sum_t   acc_x;
    sum_t   acc_y;
    logic   dark;

    // Pupil is darker than the threshold
    assign dark = pixel_valid && (pixel < threshold);

    // ------------------------------
    // Running sums over one frame
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            acc_s     <= '0;
            acc_x     <= '0;
            acc_y     <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= frame_end;
            if (frame_end) begin
                acc_s <= '0;
                acc_x <= '0;
                acc_y <= '0;
            end else if (dark) begin
                acc_s <= acc_s + count_t'(1);
                acc_x <= acc_x + sum_t'(x);
                acc_y <= acc_y + sum_t'(y);
            end
        end
    end

    // Snapshot for the divider, valid with sum_valid
    always_ff @(posedge cclk) begin
        if (frame_end) begin
            sum_s  <= acc_s;
            sum_x  <= acc_x;
            sum_y  <= acc_y;
            sum_id <= frame_id;
        end
    end

endmodule

`default_nettype wire

// ==== src/centroid_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module centroid_divider import eye_tracker_pkg::*; (
    input  wire            cclk,
    input  wire            rst,
    input  wire            sum_valid,
    input  wire count_t    sum_s,
    input  wire sum_t      sum_x,
    input  wire sum_t      sum_y,
    input  wire frame_id_t sum_id,
    input  wire            credit_return,
    output logic           result_valid,
    output frame_id_t      result_id,
    output count_t         result_count,
    output coord_t         result_cx,
    output coord_t         result_cy
);

    div_state_t              state;
    logic [RESULT_CNT_W-1:0] credits;
    logic [STEP_W-1:0]       step;
    logic                    last_step;
    logic                    send;

    // Dividend shifts out of the top while quotient bits enter at the bottom
    sum_t                    quot;
    sum_t                    quot_next;
    sum_t                    sum_y_q;
    count_t                  rem;
    count_t                  rem_next;
    logic [$bits(count_t):0] rem_shift;
    logic [$bits(count_t):0] diff;
    logic                    q_bit;

    // ------------------------------
    // Restoring divide step
    // ------------------------------
    assign rem_shift = {rem, quot[$bits(sum_t)-1]};
    assign diff      = rem_shift - {1'b0, result_count};
    assign q_bit     = ~diff[$bits(count_t)];
    assign rem_next  = q_bit ? diff[$bits(count_t)-1:0] : rem_shift[$bits(count_t)-1:0];
    assign quot_next = {quot[$bits(sum_t)-2:0], q_bit};

    assign last_step = step == STEP_W'($bits(sum_t) - 1);
    assign send      = (state == DIV_SEND) && (credits != '0);

    always_ff @(posedge cclk) begin
        if (rst) begin
            state        <= DIV_IDLE;
            credits      <= RESULT_CNT_W'(RESULT_DEPTH);
            result_valid <= 1'b0;
        end else begin
            result_valid <= send;
            credits      <= credits + RESULT_CNT_W'(credit_return) - RESULT_CNT_W'(send);
            case (state)
                DIV_IDLE: begin
                    // Sums arriving outside IDLE are dropped
                    if (sum_valid) begin
                        state <= (sum_s == '0) ? DIV_SEND : DIV_X;
                    end
                end
                DIV_X: begin
                    if (last_step) begin
                        state <= DIV_Y;
                    end
                end
                DIV_Y: begin
                    if (last_step) begin
                        state <= DIV_SEND;
                    end
                end
                DIV_SEND: begin
                    if (send) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge cclk) begin
        case (state)
            DIV_IDLE: begin
                if (sum_valid) begin
                    result_id    <= sum_id;
                    result_count <= sum_s;
                    result_cx    <= '0;
                    result_cy    <= '0;
                    quot         <= sum_x;
                    sum_y_q      <= sum_y;
                    rem          <= '0;
                    step         <= '0;
                end
            end
            DIV_X, DIV_Y: begin
                quot <= quot_next;
                rem  <= rem_next;
                step <= step + 1'b1;
                if (last_step && state == DIV_X) begin
                    result_cx <= quot_next[$bits(coord_t)-1:0];
                    quot      <= sum_y_q;
                    rem       <= '0;
                    step      <= '0;
                end else if (last_step) begin
                    result_cy <= quot_next[$bits(coord_t)-1:0];
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/result_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_fifo import eye_tracker_pkg::*; (
    input  wire            cclk,
    input  wire            rst,
    input  wire            result_valid,
    input  wire frame_id_t result_id,
    input  wire count_t    result_count,
    input  wire coord_t    result_cx,
    input  wire coord_t    result_cy,
    input  wire            pop,
    output logic           fifo_nonempty,
    output frame_id_t      head_id,
    output count_t         head_count,
    output coord_t         head_cx,
    output coord_t         head_cy,
    output logic           credit_return
);

    frame_id_t               mem_id    [RESULT_DEPTH];
    count_t                  mem_count [RESULT_DEPTH];
    coord_t                  mem_cx    [RESULT_DEPTH];
    coord_t                  mem_cy    [RESULT_DEPTH];
    logic [RESULT_PTR_W-1:0] wr_ptr;
    logic [RESULT_PTR_W-1:0] rd_ptr;
    logic [RESULT_CNT_W-1:0] occupancy;
    logic                    do_pop;

    assign fifo_nonempty = occupancy != '0;
    assign do_pop        = pop & fifo_nonempty;

    assign head_id    = mem_id[rd_ptr];
    assign head_count = mem_count[rd_ptr];
    assign head_cx    = mem_cx[rd_ptr];
    assign head_cy    = mem_cy[rd_ptr];

    // No full check, the sender only writes against credits
    always_ff @(posedge cclk) begin
        if (result_valid) begin
            mem_id[wr_ptr]    <= result_id;
            mem_count[wr_ptr] <= result_count;
            mem_cx[wr_ptr]    <= result_cx;
            mem_cy[wr_ptr]    <= result_cy;
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge cclk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            occupancy     <= '0;
            credit_return <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr + RESULT_PTR_W'(result_valid);
            rd_ptr        <= rd_ptr + RESULT_PTR_W'(do_pop);
            occupancy     <= occupancy + RESULT_CNT_W'(result_valid) - RESULT_CNT_W'(do_pop);
            credit_return <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== src/uart_result_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_result_tx import eye_tracker_pkg::*; (
    input  wire            cclk,
    input  wire            rst,
    input  wire            fifo_nonempty,
    input  wire frame_id_t head_id,
    input  wire count_t    head_count,
    input  wire coord_t    head_cx,
    input  wire coord_t    head_cy,
    output logic           pop,
    output logic           uart_txd
);

    tx_state_t             state;
    logic [CLK_CNT_W-1:0]  clk_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [BYTE_IDX_W-1:0] byte_idx;
    logic                  bit_done;
    byte_t                 cur_byte;
    frame_id_t             pkt_id;
    count_t                pkt_count;
    coord_t                pkt_cx;
    coord_t                pkt_cy;

    assign pop      = (state == TX_IDLE) && fifo_nonempty;
    assign bit_done = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);

    // Head entry is held for the whole packet
    always_ff @(posedge cclk) begin
        if (pop) begin
            pkt_id    <= head_id;
            pkt_count <= head_count;
            pkt_cx    <= head_cx;
            pkt_cy    <= head_cy;
        end
    end

    // ------------------------------
    // Packet byte order
    // ------------------------------
    always_comb begin
        case (byte_idx)
            4'd0:    cur_byte = SYNC_BYTE;
            4'd1:    cur_byte = pkt_id;
            4'd2:    cur_byte = byte_t'(pkt_cx[9:8]);
            4'd3:    cur_byte = pkt_cx[7:0];
            4'd4:    cur_byte = byte_t'(pkt_cy[9:8]);
            4'd5:    cur_byte = pkt_cy[7:0];
            4'd6:    cur_byte = byte_t'(pkt_count[19:16]);
            4'd7:    cur_byte = pkt_count[15:8];
            default: cur_byte = pkt_count[7:0];
        endcase
    end

    // ------------------------------
    // 8N1 serializer, LSB first
    // ------------------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            state    <= TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            uart_txd <= 1'b1;
        end else begin
            clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt  <= '0;
                    uart_txd <= 1'b1;
                    if (fifo_nonempty) begin
                        byte_idx <= '0;
                        uart_txd <= 1'b0;
                        state    <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        bit_idx  <= '0;
                        uart_txd <= cur_byte[0];
                        state    <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == BIT_IDX_W'($bits(byte_t) - 1)) begin
                            uart_txd <= 1'b1;
                            state    <= TX_STOP;
                        end else begin
                            bit_idx  <= bit_idx + 1'b1;
                            uart_txd <= cur_byte[bit_idx + 1'b1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        if (byte_idx == BYTE_IDX_W'(PACKET_BYTES - 1)) begin
                            state <= TX_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            uart_txd <= 1'b0;
                            state    <= TX_START;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/eye_tracker_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eye_tracker_top import eye_tracker_pkg::*; (
    input  wire         cclk,
    input  wire         rst,
    input  wire         fval,
    input  wire         lval,
    input  wire         dval,
    input  wire pixel_t data,
    input  wire pixel_t threshold,
    output logic        uart_txd
);

    // Camera to accumulator
    logic      pixel_valid;
    pixel_t    pixel;
    coord_t    x;
    coord_t    y;
    logic      frame_end;
    frame_id_t frame_id;

    // Accumulator to divider
    logic      sum_valid;
    count_t    sum_s;
    sum_t      sum_x;
    sum_t      sum_y;
    frame_id_t sum_id;

    // Divider to FIFO, with credits back
    logic      result_valid;
    frame_id_t result_id;
    count_t    result_count;
    coord_t    result_cx;
    coord_t    result_cy;
    logic      credit_return;

    // FIFO to transmitter
    logic      fifo_nonempty;
    frame_id_t head_id;
    count_t    head_count;
    coord_t    head_cx;
    coord_t    head_cy;
    logic      pop;

    camera_input u_camera_input (
        .cclk(cclk), .rst(rst),
        .fval(fval), .lval(lval), .dval(dval), .data(data),
        .pixel_valid(pixel_valid), .pixel(pixel), .x(x), .y(y),
        .frame_end(frame_end), .frame_id(frame_id)
    );

    centroid_accum u_centroid_accum (
        .cclk(cclk), .rst(rst),
        .pixel_valid(pixel_valid), .pixel(pixel), .x(x), .y(y),
        .frame_end(frame_end), .frame_id(frame_id), .threshold(threshold),
        .sum_valid(sum_valid), .sum_s(sum_s), .sum_x(sum_x), .sum_y(sum_y), .sum_id(sum_id)
    );

    centroid_divider u_centroid_divider (
        .cclk(cclk), .rst(rst),
        .sum_valid(sum_valid), .sum_s(sum_s), .sum_x(sum_x), .sum_y(sum_y), .sum_id(sum_id),
        .credit_return(credit_return),
        .result_valid(result_valid), .result_id(result_id), .result_count(result_count),
        .result_cx(result_cx), .result_cy(result_cy)
    );

    result_fifo u_result_fifo (
        .cclk(cclk), .rst(rst),
        .result_valid(result_valid), .result_id(result_id), .result_count(result_count),
        .result_cx(result_cx), .result_cy(result_cy),
        .pop(pop), .fifo_nonempty(fifo_nonempty),
        .head_id(head_id), .head_count(head_count), .head_cx(head_cx), .head_cy(head_cy),
        .credit_return(credit_return)
    );

    uart_result_tx u_uart_result_tx (
        .cclk(cclk), .rst(rst),
        .fifo_nonempty(fifo_nonempty),
        .head_id(head_id), .head_count(head_count), .head_cx(head_cx), .head_cy(head_cy),
        .pop(pop), .uart_txd(uart_txd)
    );

endmodule

`default_nettype wire

// ==== test/tb_eye_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eye_tracker import eye_tracker_pkg::*; ();

    localparam int     CLK_PERIOD  = 20;
    localparam int     FRAME_W     = 16;
    localparam int     FRAME_H     = 12;
    localparam pixel_t THRESH      = 8'h40;
    localparam int     START_LIMIT = 6000;
    localparam int     GAP_LIMIT   = 4 * CLKS_PER_BIT;
    localparam int     IDLE_CYCLES = 300;
    localparam int     DRAIN_LIMIT = 12000;

    // Start, eight data bits and stop
    localparam int     BYTE_TIME   = 10 * CLKS_PER_BIT * CLK_PERIOD;

    // Frame contents
    localparam int KIND_RANDOM = 0;
    localparam int KIND_BRIGHT = 1;
    localparam int KIND_DARK   = 2;
    localparam int KIND_SINGLE = 3;

    logic      cclk = 1'b0;
    logic      rst;
    logic      fval;
    logic      lval;
    logic      dval;
    pixel_t    data;
    pixel_t    threshold;
    logic      uart_txd;

    // Per frame number
    pixel_t    frame_pix  [256][FRAME_H][FRAME_W];
    int        frame_kind [256];
    coord_t    single_x   [256];
    coord_t    single_y   [256];
    logic      frame_sent [256];
    logic      seen       [256];

    frame_id_t next_id;
    frame_id_t last_rx_id;
    int        packets_rx;
    logic      rx_busy;
    logic      first_frame_ended;
    time       first_end_time;

    eye_tracker_top u_dut (
        .cclk(cclk), .rst(rst),
        .fval(fval), .lval(lval), .dval(dval), .data(data),
        .threshold(threshold), .uart_txd(uart_txd)
    );

    always #(CLK_PERIOD / 2) cclk = ~cclk;

    // ------------------------------
    // Failure handling and compares
    // ------------------------------
    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_frame_id(input string name, input frame_id_t got, input frame_id_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Dark pixel count and truncated mean position of a stored frame
    function automatic void reference_result(input frame_id_t id, output count_t cnt,
                                             output coord_t cx, output coord_t cy);
        sum_t sx;
        sum_t sy;
        sx  = '0;
        sy  = '0;
        cnt = '0;
        for (int r = 0; r < FRAME_H; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                if (frame_pix[id][r][c] < THRESH) begin
                    cnt = cnt + count_t'(1);
                    sx  = sx + sum_t'(c);
                    sy  = sy + sum_t'(r);
                end
            end
        end
        cx = (cnt == '0) ? '0 : coord_t'(sx / sum_t'(cnt));
        cy = (cnt == '0) ? '0 : coord_t'(sy / sum_t'(cnt));
    endfunction

    function automatic int random_kind();
        int pick;
        pick = int'($urandom_range(7, 0));
        if (pick == 0) begin
            return KIND_SINGLE;
        end
        return (pick == 1) ? KIND_BRIGHT : KIND_RANDOM;
    endfunction

    // ------------------------------
    // Camera stimulus
    // ------------------------------
    task automatic drive_cycle(input logic f, input logic l, input logic d, input pixel_t v);
        @(posedge cclk);
        fval <= f;
        lval <= l;
        dval <= d;
        data <= v;
    endtask

    task automatic send_frame(input int kind, input int gap);
        int     sx;
        int     sy;
        pixel_t v;
        sx = int'($urandom_range(FRAME_W - 1, 0));
        sy = int'($urandom_range(FRAME_H - 1, 0));
        for (int r = 0; r < FRAME_H; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                case (kind)
                    KIND_DARK:   v = pixel_t'($urandom_range(int'(THRESH) - 1, 0));
                    KIND_BRIGHT: v = pixel_t'($urandom_range(255, int'(THRESH)));
                    KIND_SINGLE: begin
                        if (r == sy && c == sx) begin
                            v = pixel_t'($urandom_range(int'(THRESH) - 1, 0));
                        end else begin
                            v = pixel_t'($urandom_range(255, int'(THRESH)));
                        end
                    end
                    default:     v = pixel_t'($urandom);
                endcase
                frame_pix[next_id][r][c] = v;
            end
        end
        frame_kind[next_id] = kind;
        single_x[next_id]   = coord_t'(sx);
        single_y[next_id]   = coord_t'(sy);
        frame_sent[next_id] = 1'b1;

        drive_cycle(1'b1, 1'b0, 1'b0, 8'h00);
        drive_cycle(1'b1, 1'b0, 1'b0, 8'h00);
        for (int r = 0; r < FRAME_H; r++) begin
            for (int c = 0; c < FRAME_W; c++) begin
                // Stall with junk data now and then
                if ($urandom_range(3, 0) == 0) begin
                    drive_cycle(1'b1, 1'b1, 1'b0, pixel_t'($urandom));
                end
                drive_cycle(1'b1, 1'b1, 1'b1, frame_pix[next_id][r][c]);
            end
            drive_cycle(1'b1, 1'b0, 1'b0, 8'h00);
            drive_cycle(1'b1, 1'b0, 1'b0, 8'h00);
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        if (!first_frame_ended) begin
            first_end_time    = $time;
            first_frame_ended = 1'b1;
        end
        next_id = next_id + 1'b1;
        repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
    endtask

    task automatic wait_for_idle();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < IDLE_CYCLES) begin
            @(negedge cclk);
            waited++;
            quiet = (uart_txd === 1'b1 && !rx_busy) ? quiet + 1 : 0;
            if (waited > DRAIN_LIMIT) begin
                $display("Timeout: uart_txd did not settle to idle within %0d cycles",
                         DRAIN_LIMIT);
                stop_run();
            end
        end
    endtask

    // ------------------------------
    // UART decoder with mid-bit sampling
    // ------------------------------
    task automatic receive_byte(input int start_limit, output byte_t value,
                                output time start_time);
        int waited;
        waited = 0;
        @(negedge cclk);
        while (uart_txd !== 1'b0) begin
            if (waited >= start_limit) begin
                $display("Timeout: no start bit on uart_txd within %0d cycles", start_limit);
                stop_run();
            end
            waited++;
            @(negedge cclk);
        end
        start_time = $time;
        repeat (CLKS_PER_BIT / 2) @(negedge cclk);
        if (uart_txd !== 1'b0) begin
            $display("Start bit on uart_txd too short at %0t", $time);
            stop_run();
        end
        for (int i = 0; i < $bits(byte_t); i++) begin
            repeat (CLKS_PER_BIT) @(negedge cclk);
            value[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge cclk);
        if (uart_txd !== 1'b1) begin
            $display("Missing stop bit on uart_txd at %0t", $time);
            stop_run();
        end
    endtask

    initial begin : uart_decoder
        byte_t     pkt [PACKET_BYTES];
        time       t_first;
        time       t_byte;
        time       t_prev;
        frame_id_t id;
        frame_id_t step;
        count_t    got_count;
        count_t    exp_count;
        coord_t    got_cx;
        coord_t    got_cy;
        coord_t    exp_cx;
        coord_t    exp_cy;
        forever begin
            receive_byte(START_LIMIT, pkt[0], t_first);
            rx_busy = 1'b1;
            if (!first_frame_ended || t_first < first_end_time) begin
                $display("uart_txd left idle before the first frame ended");
                stop_run();
            end
            check_byte("sync byte", pkt[0], SYNC_BYTE);
            t_prev = t_first;
            for (int i = 1; i < PACKET_BYTES; i++) begin
                receive_byte(GAP_LIMIT, pkt[i], t_byte);
                if (t_byte - t_prev != time'(BYTE_TIME)) begin
                    $display("Byte %0d of a packet started %0t after the previous byte",
                             i, t_byte - t_prev);
                    stop_run();
                end
                t_prev = t_byte;
            end

            id = pkt[1];
            if (!frame_sent[id]) begin
                $display("Packet carries frame number %0d, which was never sent", id);
                stop_run();
            end
            // Skips are allowed but a repeat or a step back is not
            step = id - last_rx_id;
            if (packets_rx > 0 && (step == '0 || step[7])) begin
                $display("Frame number %0d arrived after %0d", id, last_rx_id);
                stop_run();
            end

            got_cx    = {pkt[2][1:0], pkt[3]};
            got_cy    = {pkt[4][1:0], pkt[5]};
            got_count = {pkt[6][3:0], pkt[7], pkt[8]};
            reference_result(id, exp_count, exp_cx, exp_cy);
            check_byte("cx high byte", pkt[2], byte_t'(exp_cx[9:8]));
            check_byte("cy high byte", pkt[4], byte_t'(exp_cy[9:8]));
            check_byte("count high byte", pkt[6], byte_t'(exp_count[19:16]));
            check_count("count", got_count, exp_count);
            check_coord("cx", got_cx, exp_cx);
            check_coord("cy", got_cy, exp_cy);

            // Frames with a known answer
            if (frame_kind[id] == KIND_SINGLE) begin
                check_coord("single pixel cx", got_cx, single_x[id]);
                check_coord("single pixel cy", got_cy, single_y[id]);
            end else if (frame_kind[id] == KIND_DARK) begin
                check_count("dark frame count", got_count, count_t'(FRAME_W * FRAME_H));
                check_coord("dark frame cx", got_cx, coord_t'((FRAME_W - 1) / 2));
                check_coord("dark frame cy", got_cy, coord_t'((FRAME_H - 1) / 2));
            end else if (frame_kind[id] == KIND_BRIGHT) begin
                check_count("bright frame count", got_count, '0);
                check_coord("bright frame cx", got_cx, '0);
                check_coord("bright frame cy", got_cy, '0);
            end

            seen[id]   = 1'b1;
            last_rx_id = id;
            packets_rx++;
            rx_busy    = 1'b0;
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main_sequence
        void'($urandom(32'hb635));
        rst       <= 1'b1;
        fval      <= 1'b0;
        lval      <= 1'b0;
        dval      <= 1'b0;
        data      <= '0;
        threshold <= THRESH;
        next_id           = '0;
        last_rx_id        = '0;
        packets_rx        = 0;
        rx_busy           = 1'b0;
        first_frame_ended = 1'b0;
        first_end_time    = 0;
        foreach (frame_sent[i]) begin
            frame_sent[i] = 1'b0;
            seen[i]       = 1'b0;
        end

        repeat (4) @(posedge cclk);
        rst <= 1'b0;

        send_frame(KIND_DARK, 20);
        send_frame(KIND_BRIGHT, 20);
        send_frame(KIND_SINGLE, 20);
        send_frame(KIND_SINGLE, 20);
        // Frames arrive much faster than packets leave
        for (int i = 0; i < 20; i++) begin
            send_frame(random_kind(), 8);
        end
        wait_for_idle();

        // One last frame into an empty pipeline
        send_frame(KIND_SINGLE, 8);
        wait_for_idle();

        check_frame_id("last packet frame", last_rx_id, next_id - 1'b1);
        if (packets_rx >= int'(next_id)) begin
            $display("No frame was dropped although frames outpaced the UART");
            stop_run();
        end
        for (int i = 0; i < 4; i++) begin
            if (!seen[i]) begin
                $display("Frame %0d never produced a packet", i);
                stop_run();
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/eye_tracker_pkg.sv
src/camera_input.sv
src/centroid_accum.sv
src/centroid_divider.sv
src/result_fifo.sv
src/uart_result_tx.sv
src/eye_tracker_top.sv
test/tb_eye_tracker.sv

// ==== Makefile ====
# Verilator flow for the eye tracker testbench

TOP := tb_eye_tracker

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

# The run returns a failing status when the testbench stops on $fatal
sim:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
